// ==== src/fix_gen_pkg.sv ====
// generator hardware constants
// word widths for tags, values and byte counts
// field indices in message order, plus the skip point
// for messages without the logon-only fields

`default_nettype none

package fix_gen_pkg;

	// value word holds up to 8 ascii bytes, right-aligned
	localparam int VALUE_W = 64;
	localparam int TAG_W   = 32;
	localparam int SIZE_W  = 4;
	localparam int FIELD_W = 4;

	// field indices, numbered in the order they go on the wire
	localparam logic [FIELD_W-1:0] FLD_BEGIN_STRING   = 4'd0;
	localparam logic [FIELD_W-1:0] FLD_BODY_LENGTH    = 4'd1;
	localparam logic [FIELD_W-1:0] FLD_MSG_TYPE       = 4'd2;
	localparam logic [FIELD_W-1:0] FLD_MSG_SEQ_NUM    = 4'd3;
	localparam logic [FIELD_W-1:0] FLD_SENDER_COMP_ID = 4'd4;
	localparam logic [FIELD_W-1:0] FLD_SENDING_TIME   = 4'd5;
	localparam logic [FIELD_W-1:0] FLD_TARGET_COMP_ID = 4'd6;
	localparam logic [FIELD_W-1:0] FLD_ENCRYPT_METHOD = 4'd7;
	localparam logic [FIELD_W-1:0] FLD_HEART_BT_INT   = 4'd8;
	localparam logic [FIELD_W-1:0] FLD_CHECKSUM       = 4'd9;

	// last field shared by all types, heartbeat and logout jump
	// from here straight to checksum
	localparam logic [FIELD_W-1:0] FLD_LAST_COMMON = FLD_TARGET_COMP_ID;

endpackage

`default_nettype wire

// ==== src/fix_proto_pkg.sv ====
// fix protocol constants
// tag strings and their byte counts
// begin string and encrypt method values
// one-hot message type codes and their msgtype strings

`default_nettype none

package fix_proto_pkg;

	import fix_gen_pkg::*;

	// tags as ascii digits, right-aligned, upper bytes zero
	localparam logic [TAG_W-1:0] TAG_BEGIN_STRING   = "8";
	localparam logic [TAG_W-1:0] TAG_BODY_LENGTH    = "9";
	localparam logic [TAG_W-1:0] TAG_MSG_TYPE       = "35";
	localparam logic [TAG_W-1:0] TAG_MSG_SEQ_NUM    = "34";
	localparam logic [TAG_W-1:0] TAG_SENDER_COMP_ID = "49";
	localparam logic [TAG_W-1:0] TAG_SENDING_TIME   = "52";
	localparam logic [TAG_W-1:0] TAG_TARGET_COMP_ID = "56";
	localparam logic [TAG_W-1:0] TAG_ENCRYPT_METHOD = "98";
	localparam logic [TAG_W-1:0] TAG_HEART_BT_INT   = "108";
	localparam logic [TAG_W-1:0] TAG_CHECKSUM       = "10";

	// tag byte counts
	localparam logic [SIZE_W-1:0] TAG_LEN_BEGIN_STRING   = 4'd1;
	localparam logic [SIZE_W-1:0] TAG_LEN_BODY_LENGTH    = 4'd1;
	localparam logic [SIZE_W-1:0] TAG_LEN_MSG_TYPE       = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_MSG_SEQ_NUM    = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_SENDER_COMP_ID = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_SENDING_TIME   = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_TARGET_COMP_ID = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_ENCRYPT_METHOD = 4'd2;
	localparam logic [SIZE_W-1:0] TAG_LEN_HEART_BT_INT   = 4'd3;
	localparam logic [SIZE_W-1:0] TAG_LEN_CHECKSUM       = 4'd2;

	// fixed values
	localparam logic [VALUE_W-1:0] BEGIN_STRING_VAL   = "FIX.4.2";
	localparam logic [SIZE_W-1:0]  BEGIN_STRING_LEN   = 4'd7;
	localparam logic [VALUE_W-1:0] ENCRYPT_METHOD_VAL = "0";
	localparam logic [SIZE_W-1:0]  ENCRYPT_METHOD_LEN = 4'd1;

	// one-hot session message types
	localparam int MSG_TYPE_W = 4;
	localparam logic [MSG_TYPE_W-1:0] MSG_LOGON     = 4'b0001;
	localparam logic [MSG_TYPE_W-1:0] MSG_HEARTBEAT = 4'b0010;
	localparam logic [MSG_TYPE_W-1:0] MSG_LOGOUT    = 4'b0100;

	// msgtype (35) value strings, all one byte
	localparam logic [VALUE_W-1:0] MSGTYPE_VAL_LOGON     = "A";
	localparam logic [VALUE_W-1:0] MSGTYPE_VAL_HEARTBEAT = "0";
	localparam logic [VALUE_W-1:0] MSGTYPE_VAL_LOGOUT    = "5";
	localparam logic [SIZE_W-1:0]  MSGTYPE_LEN           = 4'd1;

endpackage

`default_nettype wire

// ==== src/field_sequencer.sv ====
// field sequencer of the fix session message generator
// walks the field list for logon, heartbeat and logout,
// one tag or value token per step, stalled by the fifo
// full flag and by the bodylength and seqnum ready inputs

`default_nettype none

module field_sequencer (
	input  wire                                  clk,
	input  wire                                  rst,
	input  wire                                  start_i,
	input  wire [fix_proto_pkg::MSG_TYPE_W-1:0]  msg_type_i,
	input  wire                                  fifo_full_i,
	input  wire                                  body_len_ready_i,
	input  wire                                  seq_ready_i,
	output logic                                 step_o,
	output logic [fix_gen_pkg::FIELD_W-1:0]      field_o,
	output logic                                 is_tag_o,
	output logic                                 last_o,
	output logic [fix_proto_pkg::MSG_TYPE_W-1:0] msg_type_o,
	output logic                                 busy_o
);

	import fix_gen_pkg::*;
	import fix_proto_pkg::*;

	logic                  busy_q;
	logic [FIELD_W-1:0]    field_q;
	logic                  tag_phase_q;
	logic [MSG_TYPE_W-1:0] msg_type_q;

	logic                  type_ok;
	logic                  start_ok;
	logic                  src_ready;
	logic [FIELD_W-1:0]    field_next;

	// only the three session types are accepted
	assign type_ok = (msg_type_i == MSG_LOGON) ||
		(msg_type_i == MSG_HEARTBEAT) ||
		(msg_type_i == MSG_LOGOUT);

	// start is ignored while a message is in flight
	assign start_ok = start_i && !busy_q && type_ok;

	// value tokens of bodylength and seqnum wait for their sources
	always_comb begin
		src_ready = 1'b1;
		if (!tag_phase_q) begin
			if (field_q == FLD_BODY_LENGTH)
				src_ready = body_len_ready_i;
			else if (field_q == FLD_MSG_SEQ_NUM)
				src_ready = seq_ready_i;
		end
	end

	// one token per cycle while the fifo has room
	assign step_o = busy_q && !fifo_full_i && src_ready;

	// heartbeat and logout skip encryptmethod and heartbtint
	always_comb begin
		if (msg_type_q != MSG_LOGON && field_q == FLD_LAST_COMMON)
			field_next = FLD_CHECKSUM;
		else
			field_next = field_q + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q      <= 1'b0;
			field_q     <= FLD_BEGIN_STRING;
			tag_phase_q <= 1'b1;
		end else if (start_ok) begin
			busy_q      <= 1'b1;
			field_q     <= FLD_BEGIN_STRING;
			tag_phase_q <= 1'b1;
		end else if (step_o) begin
			if (tag_phase_q) begin
				// checksum goes out as a tag only, value is added downstream
				if (field_q == FLD_CHECKSUM)
					busy_q <= 1'b0;
				else
					tag_phase_q <= 1'b0;
			end else begin
				tag_phase_q <= 1'b1;
				field_q     <= field_next;
			end
		end
	end

	// type held for the whole message
	always_ff @(posedge clk) begin
		if (start_ok)
			msg_type_q <= msg_type_i;
	end

	assign field_o    = field_q;
	assign is_tag_o   = tag_phase_q;
	assign last_o     = tag_phase_q && (field_q == FLD_CHECKSUM);
	assign msg_type_o = msg_type_q;
	assign busy_o     = busy_q;

endmodule

`default_nettype wire

// ==== src/field_encoder.sv ====
// field encoder, output register stage
// maps field index and tag/value phase to token data and size,
// registered on each step from the sequencer

`default_nettype none

module field_encoder (
	input  wire                                 clk,
	input  wire                                 rst,
	input  wire                                 step_i,
	input  wire [fix_gen_pkg::FIELD_W-1:0]      field_i,
	input  wire                                 is_tag_i,
	input  wire                                 last_i,
	input  wire [fix_proto_pkg::MSG_TYPE_W-1:0] msg_type_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      body_len_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       body_len_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      seq_num_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       seq_num_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      sender_id_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       sender_id_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      target_id_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       target_id_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      send_time_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       send_time_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      heart_bt_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       heart_bt_size_i,
	output logic                                tok_valid_o,
	output logic                                tok_is_tag_o,
	output logic [fix_gen_pkg::VALUE_W-1:0]     tok_data_o,
	output logic [fix_gen_pkg::SIZE_W-1:0]      tok_size_o,
	output logic                                tok_last_o
);

	import fix_gen_pkg::*;
	import fix_proto_pkg::*;

	logic [TAG_W-1:0]   tag_word;
	logic [SIZE_W-1:0]  tag_len;
	logic [VALUE_W-1:0] val_word;
	logic [SIZE_W-1:0]  val_len;
	logic [VALUE_W-1:0] type_str;

	// msgtype string from the latched one-hot code
	always_comb begin
		case (msg_type_i)
			MSG_LOGON:     type_str = MSGTYPE_VAL_LOGON;
			MSG_HEARTBEAT: type_str = MSGTYPE_VAL_HEARTBEAT;
			MSG_LOGOUT:    type_str = MSGTYPE_VAL_LOGOUT;
			default:       type_str = '0;
		endcase
	end

	// tag lookup
	always_comb begin
		case (field_i)
			FLD_BEGIN_STRING:   {tag_word, tag_len} = {TAG_BEGIN_STRING, TAG_LEN_BEGIN_STRING};
			FLD_BODY_LENGTH:    {tag_word, tag_len} = {TAG_BODY_LENGTH, TAG_LEN_BODY_LENGTH};
			FLD_MSG_TYPE:       {tag_word, tag_len} = {TAG_MSG_TYPE, TAG_LEN_MSG_TYPE};
			FLD_MSG_SEQ_NUM:    {tag_word, tag_len} = {TAG_MSG_SEQ_NUM, TAG_LEN_MSG_SEQ_NUM};
			FLD_SENDER_COMP_ID: {tag_word, tag_len} = {TAG_SENDER_COMP_ID, TAG_LEN_SENDER_COMP_ID};
			FLD_SENDING_TIME:   {tag_word, tag_len} = {TAG_SENDING_TIME, TAG_LEN_SENDING_TIME};
			FLD_TARGET_COMP_ID: {tag_word, tag_len} = {TAG_TARGET_COMP_ID, TAG_LEN_TARGET_COMP_ID};
			FLD_ENCRYPT_METHOD: {tag_word, tag_len} = {TAG_ENCRYPT_METHOD, TAG_LEN_ENCRYPT_METHOD};
			FLD_HEART_BT_INT:   {tag_word, tag_len} = {TAG_HEART_BT_INT, TAG_LEN_HEART_BT_INT};
			default:            {tag_word, tag_len} = {TAG_CHECKSUM, TAG_LEN_CHECKSUM};
		endcase
	end

	// value source, constant or input word
	always_comb begin
		case (field_i)
			FLD_BEGIN_STRING:   {val_word, val_len} = {BEGIN_STRING_VAL, BEGIN_STRING_LEN};
			FLD_BODY_LENGTH:    {val_word, val_len} = {body_len_i, body_len_size_i};
			FLD_MSG_TYPE:       {val_word, val_len} = {type_str, MSGTYPE_LEN};
			FLD_MSG_SEQ_NUM:    {val_word, val_len} = {seq_num_i, seq_num_size_i};
			FLD_SENDER_COMP_ID: {val_word, val_len} = {sender_id_i, sender_id_size_i};
			FLD_SENDING_TIME:   {val_word, val_len} = {send_time_i, send_time_size_i};
			FLD_TARGET_COMP_ID: {val_word, val_len} = {target_id_i, target_id_size_i};
			FLD_ENCRYPT_METHOD: {val_word, val_len} = {ENCRYPT_METHOD_VAL, ENCRYPT_METHOD_LEN};
			FLD_HEART_BT_INT:   {val_word, val_len} = {heart_bt_i, heart_bt_size_i};
			// checksum has no value token here
			default:            {val_word, val_len} = '0;
		endcase
	end

	// valid and last are pulses, one cycle after the step
	always_ff @(posedge clk) begin
		if (rst) begin
			tok_valid_o <= 1'b0;
			tok_last_o  <= 1'b0;
		end else begin
			tok_valid_o <= step_i;
			tok_last_o  <= step_i && last_i;
		end
	end

	always_ff @(posedge clk) begin
		if (step_i) begin
			tok_is_tag_o <= is_tag_i;
			tok_data_o   <= is_tag_i ? VALUE_W'(tag_word) : val_word;
			tok_size_o   <= is_tag_i ? tag_len : val_len;
		end
	end

endmodule

`default_nettype wire

// ==== src/fix_msg_builder.sv ====
// top level of the fix session message generator
// field sequencer feeding the token output register stage

`default_nettype none

module fix_msg_builder (
	input  wire                                 clk,
	input  wire                                 rst,
	input  wire                                 start_i,
	input  wire [fix_proto_pkg::MSG_TYPE_W-1:0] msg_type_i,
	input  wire                                 fifo_full_i,
	input  wire                                 body_len_ready_i,
	input  wire                                 seq_ready_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      body_len_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       body_len_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      seq_num_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       seq_num_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      sender_id_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       sender_id_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      target_id_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       target_id_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      send_time_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       send_time_size_i,
	input  wire [fix_gen_pkg::VALUE_W-1:0]      heart_bt_i,
	input  wire [fix_gen_pkg::SIZE_W-1:0]       heart_bt_size_i,
	output logic                                tok_valid_o,
	output logic                                tok_is_tag_o,
	output logic [fix_gen_pkg::VALUE_W-1:0]     tok_data_o,
	output logic [fix_gen_pkg::SIZE_W-1:0]      tok_size_o,
	output logic                                tok_last_o,
	output logic                                busy_o
);

	import fix_gen_pkg::*;
	import fix_proto_pkg::*;

	// sequencer to encoder
	logic                  step;
	logic [FIELD_W-1:0]    field;
	logic                  is_tag;
	logic                  last;
	logic [MSG_TYPE_W-1:0] msg_type_l;

	field_sequencer field_sequencer_inst (
		.clk              (clk),
		.rst              (rst),
		.start_i          (start_i),
		.msg_type_i       (msg_type_i),
		.fifo_full_i      (fifo_full_i),
		.body_len_ready_i (body_len_ready_i),
		.seq_ready_i      (seq_ready_i),
		.step_o           (step),
		.field_o          (field),
		.is_tag_o         (is_tag),
		.last_o           (last),
		.msg_type_o       (msg_type_l),
		.busy_o           (busy_o)
	);

	field_encoder field_encoder_inst (
		.clk              (clk),
		.rst              (rst),
		.step_i           (step),
		.field_i          (field),
		.is_tag_i         (is_tag),
		.last_i           (last),
		.msg_type_i       (msg_type_l),
		.body_len_i       (body_len_i),
		.body_len_size_i  (body_len_size_i),
		.seq_num_i        (seq_num_i),
		.seq_num_size_i   (seq_num_size_i),
		.sender_id_i      (sender_id_i),
		.sender_id_size_i (sender_id_size_i),
		.target_id_i      (target_id_i),
		.target_id_size_i (target_id_size_i),
		.send_time_i      (send_time_i),
		.send_time_size_i (send_time_size_i),
		.heart_bt_i       (heart_bt_i),
		.heart_bt_size_i  (heart_bt_size_i),
		.tok_valid_o      (tok_valid_o),
		.tok_is_tag_o     (tok_is_tag_o),
		.tok_data_o       (tok_data_o),
		.tok_size_o       (tok_size_o),
		.tok_last_o       (tok_last_o)
	);

endmodule

`default_nettype wire

// ==== verif/fix_msg_builder_properties.sv ====
// concurrent checks on the token output of the message builder
// bound into the fix_msg_builder top level

`default_nettype none

module fix_msg_builder_properties (
	input wire clk,
	input wire rst,
	input wire fifo_full_i,
	input wire tok_valid_o,
	input wire tok_is_tag_o,
	input wire tok_last_o,
	input wire busy_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// a full cycle blocks the token of the following cycle
	no_token_after_full: assert property (@(posedge clk) disable iff (rst)
		fifo_full_i |=> !tok_valid_o)
		else $error("token emitted after a fifo full cycle");

	// last marks the checksum tag only
	last_is_valid_tag: assert property (@(posedge clk) disable iff (rst)
		tok_last_o |-> (tok_valid_o && tok_is_tag_o))
		else $error("last flag without a valid tag token");

	no_token_when_idle: assert property (@(posedge clk) disable iff (rst)
		!busy_o |=> !tok_valid_o)
		else $error("token emitted after an idle cycle");

endmodule

bind fix_msg_builder fix_msg_builder_properties fix_msg_builder_properties_inst (
	.clk          (clk),
	.rst          (rst),
	.fifo_full_i  (fifo_full_i),
	.tok_valid_o  (tok_valid_o),
	.tok_is_tag_o (tok_is_tag_o),
	.tok_last_o   (tok_last_o),
	.busy_o       (busy_o)
);

`default_nettype wire

// ==== verif/tb_fix_msg_builder.sv ====
// testbench for the fix session message generator
// random types, values, fifo stalls and ready delays from an lcg
// token model built from the field order, checked by a monitor

`default_nettype none

module tb_fix_msg_builder;

	timeunit 1ns;
	timeprecision 100ps;

	import fix_gen_pkg::*;
	import fix_proto_pkg::*;

	localparam int NUM_MSGS   = 40;
	localparam int BUSY_LIMIT = 500;
	localparam int TOK_LIMIT  = 10;
	localparam logic [1:0] NEED_NONE = 2'd0;
	localparam logic [1:0] NEED_BODY = 2'd1;
	localparam logic [1:0] NEED_SEQ  = 2'd2;

	logic clk;
	logic rst;
	logic start;
	logic [MSG_TYPE_W-1:0] msg_type;
	logic fifo_full;
	logic body_len_ready;
	logic seq_ready;
	// 0 body_len, 1 seq_num, 2 sender_id, 3 target_id, 4 send_time, 5 heart_bt
	logic [VALUE_W-1:0] vals [6];
	logic [SIZE_W-1:0]  sizes [6];
	logic tok_valid;
	logic tok_is_tag;
	logic [VALUE_W-1:0] tok_data;
	logic [SIZE_W-1:0]  tok_size;
	logic tok_last;
	logic busy;

	logic [31:0] lcg_state;
	// expected token: {need, last, is_tag, size, data}
	logic [71:0] exp_q [$];
	// model state, message in flight and whether a step is due
	logic model_busy;
	logic step_due;

	fix_msg_builder fix_msg_builder_inst (
		.clk              (clk),
		.rst              (rst),
		.start_i          (start),
		.msg_type_i       (msg_type),
		.fifo_full_i      (fifo_full),
		.body_len_ready_i (body_len_ready),
		.seq_ready_i      (seq_ready),
		.body_len_i       (vals[0]),
		.body_len_size_i  (sizes[0]),
		.seq_num_i        (vals[1]),
		.seq_num_size_i   (sizes[1]),
		.sender_id_i      (vals[2]),
		.sender_id_size_i (sizes[2]),
		.target_id_i      (vals[3]),
		.target_id_size_i (sizes[3]),
		.send_time_i      (vals[4]),
		.send_time_size_i (sizes[4]),
		.heart_bt_i       (vals[5]),
		.heart_bt_size_i  (sizes[5]),
		.tok_valid_o      (tok_valid),
		.tok_is_tag_o     (tok_is_tag),
		.tok_data_o       (tok_data),
		.tok_size_o       (tok_size),
		.tok_last_o       (tok_last),
		.busy_o           (busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits only, the low bits of an lcg cycle quickly
	function automatic int unsigned rand_range(input int unsigned n);
		logic [31:0] r;
		r = rand_next();
		return (r >> 16) % n;
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped on timeout");
	endtask

	function automatic void expect_field(input logic [TAG_W-1:0] tag,
		input logic [SIZE_W-1:0] tag_len, input logic [VALUE_W-1:0] val,
		input logic [SIZE_W-1:0] val_len, input logic [1:0] need);
		exp_q.push_back({NEED_NONE, 1'b0, 1'b1, tag_len, 64'(tag)});
		exp_q.push_back({need, 1'b0, 1'b0, val_len, val});
	endfunction

	// fixed field order, logon adds encryptmethod and heartbtint
	function automatic void build_model(input logic [MSG_TYPE_W-1:0] mtype);
		logic [VALUE_W-1:0] type_val;
		if (mtype == MSG_LOGON)
			type_val = MSGTYPE_VAL_LOGON;
		else if (mtype == MSG_HEARTBEAT)
			type_val = MSGTYPE_VAL_HEARTBEAT;
		else
			type_val = MSGTYPE_VAL_LOGOUT;
		expect_field(TAG_BEGIN_STRING, TAG_LEN_BEGIN_STRING,
			BEGIN_STRING_VAL, BEGIN_STRING_LEN, NEED_NONE);
		expect_field(TAG_BODY_LENGTH, TAG_LEN_BODY_LENGTH, vals[0], sizes[0], NEED_BODY);
		expect_field(TAG_MSG_TYPE, TAG_LEN_MSG_TYPE, type_val, 4'd1, NEED_NONE);
		expect_field(TAG_MSG_SEQ_NUM, TAG_LEN_MSG_SEQ_NUM, vals[1], sizes[1], NEED_SEQ);
		expect_field(TAG_SENDER_COMP_ID, TAG_LEN_SENDER_COMP_ID, vals[2], sizes[2], NEED_NONE);
		expect_field(TAG_SENDING_TIME, TAG_LEN_SENDING_TIME, vals[4], sizes[4], NEED_NONE);
		expect_field(TAG_TARGET_COMP_ID, TAG_LEN_TARGET_COMP_ID, vals[3], sizes[3], NEED_NONE);
		if (mtype == MSG_LOGON) begin
			expect_field(TAG_ENCRYPT_METHOD, TAG_LEN_ENCRYPT_METHOD,
				ENCRYPT_METHOD_VAL, ENCRYPT_METHOD_LEN, NEED_NONE);
			expect_field(TAG_HEART_BT_INT, TAG_LEN_HEART_BT_INT, vals[5], sizes[5], NEED_NONE);
		end
		// checksum tag only, flagged last
		exp_q.push_back({NEED_NONE, 1'b1, 1'b1, TAG_LEN_CHECKSUM, 64'(TAG_CHECKSUM)});
	endfunction

	// outputs sampled mid-cycle, a step shows as a token one cycle later
	always @(negedge clk) begin : token_monitor
		logic [71:0] e;
		logic [1:0]  need;
		logic        src_ok;
		if (rst) begin
			model_busy = 1'b0;
			step_due   = 1'b0;
		end else begin
			check_value(busy, model_busy, "busy flag");
			check_value(tok_valid, step_due, "token valid timing");
			if (tok_valid) begin
				e = exp_q.pop_front();
				check_value(tok_data, e[63:0], "token data");
				check_value(tok_size, e[67:64], "token size");
				check_value(tok_is_tag, e[68], "tag flag");
				check_value(tok_last, e[69], "last flag");
			end else begin
				check_value(tok_last, 1'b0, "last flag without valid");
			end
			// next token goes out unless the fifo is full or its source is not ready
			need   = (exp_q.size() != 0) ? exp_q[0][71:70] : NEED_NONE;
			src_ok = (need == NEED_BODY) ? body_len_ready :
				(need == NEED_SEQ) ? seq_ready : 1'b1;
			step_due = model_busy && (exp_q.size() != 0) && !fifo_full && src_ok;
			if (model_busy) begin
				if (step_due && exp_q[0][69])
					model_busy = 1'b0;
			end else if (start && (msg_type == MSG_LOGON || msg_type == MSG_HEARTBEAT ||
				msg_type == MSG_LOGOUT)) begin
				model_busy = 1'b1;
			end
		end
	end

	task automatic try_invalid_start();
		logic [MSG_TYPE_W-1:0] bad;
		bad = 4'(rand_range(16));
		if (bad == MSG_LOGON || bad == MSG_HEARTBEAT || bad == MSG_LOGOUT)
			bad = 4'b1000;
		start    = 1'b1;
		msg_type = bad;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_value(busy, 1'b0, "busy after a start with an invalid type");
		repeat (2) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin : stimulus
		int cyc;
		int body_delay;
		int seq_delay;
		logic [MSG_TYPE_W-1:0] mtype;
		lcg_state      = 32'hd4fb;
		rst            = 1'b1;
		start          = 1'b0;
		msg_type       = '0;
		fifo_full      = 1'b0;
		body_len_ready = 1'b0;
		seq_ready      = 1'b0;
		for (int i = 0; i < 6; i++) begin
			vals[i]  = '0;
			sizes[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_value(busy, 1'b0, "busy after reset");
			check_value(tok_valid, 1'b0, "valid after reset");
			check_value(tok_last, 1'b0, "last after reset");
		end

		for (int n = 0; n < NUM_MSGS; n++) begin
			if (rand_range(8) == 0)
				try_invalid_start();
			case (rand_range(3))
				0:       mtype = MSG_LOGON;
				1:       mtype = MSG_HEARTBEAT;
				default: mtype = MSG_LOGOUT;
			endcase
			// ascii-like words right-aligned in size bytes
			for (int i = 0; i < 6; i++) begin
				sizes[i] = 4'(rand_range(8) + 1);
				vals[i]  = {rand_next(), rand_next()} & (~64'd0 >> (8 * (8 - sizes[i])));
			end
			body_delay = rand_range(6);
			seq_delay  = rand_range(6);
			build_model(mtype);
			start    = 1'b1;
			msg_type = mtype;
			@(posedge clk);
			#1;
			start = 1'b0;
			cyc   = 0;
			while (busy) begin
				fifo_full      = (rand_range(10) < 3);
				body_len_ready = (cyc >= body_delay);
				seq_ready      = (cyc >= seq_delay);
				// start while busy, another valid type, must be ignored
				start    = (rand_range(10) == 0);
				msg_type = (mtype == MSG_LOGON) ? MSG_LOGOUT : MSG_LOGON;
				@(posedge clk);
				#1;
				cyc++;
				if (cyc > BUSY_LIMIT)
					timeout_fail("busy to fall");
			end
			start          = 1'b0;
			fifo_full      = 1'b0;
			body_len_ready = 1'b0;
			seq_ready      = 1'b0;
			cyc            = 0;
			while (exp_q.size() != 0) begin
				@(posedge clk);
				#1;
				cyc++;
				if (cyc > TOK_LIMIT)
					timeout_fail("the remaining tokens");
			end
		end

		repeat (4) @(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/fix_gen_pkg.sv
src/fix_proto_pkg.sv
src/field_sequencer.sv
src/field_encoder.sv
src/fix_msg_builder.sv
verif/fix_msg_builder_properties.sv
verif/tb_fix_msg_builder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, decide pass from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_fix_msg_builder -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && exit 0 || { echo "run failed"; exit 1; }
